// File: hw/brdec_pkg.sv
// Branch decode shared types
package brdec_pkg;

	// ========================================
	// Address and displacement types
	// ========================================

	// Instruction address as seen by fetch and decode
	typedef logic [31:0] addr_t;

	// Branch displacement in bytes, signed so that its sign drives the static prediction
	typedef logic signed [15:0] disp_t;

	// Return addresses point at the instruction after the call
	localparam addr_t INSTR_BYTES = 32'd4;

	// BRK with this function code is an exception return
	localparam logic [7:0] ERET_FUNC = 8'd1;

	// ========================================
	// Opcodes
	// ========================================

	// Only the opcodes that decode looks at are listed, plus two ordinary ones
	typedef enum logic [6:0] {
		OP_BRK    = 7'd0,
		OP_ADD    = 7'd4,
		OP_JSR    = 7'd32,
		OP_JSRN   = 7'd33,
		OP_RTD    = 7'd34,
		OP_BCC8   = 7'd40,
		OP_BCC16  = 7'd41,
		OP_BCC32  = 7'd42,
		OP_BCC64  = 7'd43,
		OP_BCCU8  = 7'd44,
		OP_BCCU16 = 7'd45,
		OP_BCCU32 = 7'd46,
		OP_BCCU64 = 7'd47,
		OP_NOP    = 7'd127
	} opcode_t;

	// Micro-op word as it leaves the instruction aligner
	// The func byte doubles as the high displacement byte of a branch
	typedef struct packed {
		logic        md;
		logic [7:0]  func;
		logic [15:0] disp_lo;
		opcode_t     opcode;
	} micro_op_t;

	// ========================================
	// Branch class and redirect bus
	// ========================================

	// Coarse branch class handed to the redirect sources
	typedef enum logic [2:0] {
		BRC_NONE = 3'd0,
		BRC_BCCD = 3'd1,
		BRC_BCCR = 3'd2,
		BRC_JSR  = 3'd3,
		BRC_JSRN = 3'd4,
		BRC_RTD  = 3'd5,
		BRC_ERET = 3'd6
	} brclass_t;

	// A fetch redirect request or grant
	typedef struct packed {
		logic  valid;
		addr_t target;
	} redirect_t;

endpackage

// File: hw/decode_brclass.sv
// Branch class decoder
module decode_brclass (
	input  brdec_pkg::micro_op_t instr,
	output brdec_pkg::brclass_t  brclass
);

	import brdec_pkg::*;

	// Pure lookup on the opcode with md and func as qualifiers
	always_comb
	begin
		case (instr.opcode)
			// All conditional branch widths share one class pair
			// Register mode means the target lives in a register
			OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64,
			OP_BCCU8, OP_BCCU16, OP_BCCU32, OP_BCCU64:
			begin
				if (instr.md)
					brclass = BRC_BCCR;
				else
					brclass = BRC_BCCD;
			end
			// Calls and returns map one to one
			OP_JSR:
				brclass = BRC_JSR;
			OP_JSRN:
				brclass = BRC_JSRN;
			OP_RTD:
				brclass = BRC_RTD;
			// Only one BRK function is an exception return
			// Every other BRK is a trap entry and not a branch here
			OP_BRK:
			begin
				if (instr.func == ERET_FUNC)
					brclass = BRC_ERET;
				else
					brclass = BRC_NONE;
			end
			default:
				brclass = BRC_NONE;
		endcase
	end

endmodule

// File: hw/branch_target.sv
// Displacement branch target
module branch_target (
	input  logic                 instr_valid,
	input  brdec_pkg::micro_op_t instr,
	input  brdec_pkg::addr_t     pc,
	input  brdec_pkg::brclass_t  brclass,
	output brdec_pkg::redirect_t tgt_req
);

	import brdec_pkg::*;

	// Displacement as carried in the micro-op
	disp_t disp;
	// Displacement widened to address width
	addr_t disp_ext;
	// Sum of pc and the displacement
	addr_t target;
	// Backward branch flag used for the static prediction
	logic  disp_neg;
	// Class qualifies for a redirect from this unit
	logic  take;

	// ========================================
	// Target computation
	// ========================================

	assign disp = disp_t'(instr.disp_lo);

	// Sign extension by replicating the top bit
	assign disp_ext = {{16{disp[15]}}, disp};

	// Displacement is in bytes so it adds straight to pc
	assign target = pc + disp_ext;

	// ========================================
	// Static prediction
	// ========================================

	// Backward branches usually close loops so they are predicted taken
	assign disp_neg = disp < 0;

	// Direct calls always go
	// A conditional goes only when it jumps backward
	assign take = (brclass == BRC_JSR) || ((brclass == BRC_BCCD) && disp_neg);

	always_comb
	begin
		tgt_req.valid  = instr_valid && take;
		tgt_req.target = target;
	end

endmodule

// File: hw/return_stack.sv
// Return address stack
module return_stack #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 instr_valid,
	input  brdec_pkg::brclass_t  brclass,
	input  brdec_pkg::addr_t     pc,
	output brdec_pkg::redirect_t ras_req
);

	import brdec_pkg::*;

	localparam int PTR_W = $clog2(RAS_DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(RAS_DEPTH);

	// Only the newest count slots hold live return addresses
	addr_t stack_mem [RAS_DEPTH];

	// Index of the newest entry
	logic [PTR_W-1:0] top_ptr;
	// Slot that the next push writes
	logic [PTR_W-1:0] push_ptr;
	// Number of live entries, saturating at the depth
	logic [PTR_W:0]   count;

	logic  push;
	logic  pop;
	logic  empty;
	addr_t push_addr;

	// ========================================
	// Push and pop decode
	// ========================================

	// Both call forms save a return address
	assign push = instr_valid && ((brclass == BRC_JSR) || (brclass == BRC_JSRN));

	assign empty = (count == '0);

	// A return on an empty stack has nothing to offer and is dropped
	assign pop = instr_valid && (brclass == BRC_RTD) && !empty;

	// Return lands on the instruction after the call
	assign push_addr = pc + INSTR_BYTES;

	// Wraps around on its own since the depth is a power of two
	assign push_ptr = top_ptr + 1'b1;

	// ========================================
	// Pointer, count and storage
	// ========================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			top_ptr <= '0;
			count   <= '0;
		end
		else if (push)
		begin
			top_ptr <= push_ptr;
			// When full the oldest slot gets overwritten and count holds
			if (count != FULL_COUNT)
				count <= count + 1'b1;
		end
		else if (pop)
		begin
			top_ptr <= top_ptr - 1'b1;
			count   <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			stack_mem[push_ptr] <= push_addr;
	end

	// Current top goes out while the return is still in decode
	always_comb
	begin
		ras_req.valid  = pop;
		ras_req.target = stack_mem[top_ptr];
	end

	// ========================================
	// Checks
	// ========================================

	a_count_bounded: assert property (@(posedge clk) disable iff (reset)
		count <= FULL_COUNT)
		else $error("return stack count above depth");

endmodule

// File: hw/redirect_arbiter.sv
// Redirect bus arbiter
module redirect_arbiter (
	input  logic                 clk,
	input  brdec_pkg::redirect_t eret_req,
	input  brdec_pkg::redirect_t ras_req,
	input  brdec_pkg::redirect_t tgt_req,
	output brdec_pkg::redirect_t redirect
);

	// Request valids gathered in priority order, highest first
	logic [2:0] req_vec;

	assign req_vec = {eret_req.valid, ras_req.valid, tgt_req.valid};

	// ========================================
	// Fixed priority grant
	// ========================================

	// Exception return beats the stack which beats the adder
	// Only one should ever be up so the order matters on a fault alone
	always_comb
	begin
		if (eret_req.valid)
		begin
			redirect = eret_req;
		end
		else if (ras_req.valid)
		begin
			redirect = ras_req;
		end
		else if (tgt_req.valid)
		begin
			redirect = tgt_req;
		end
		else
		begin
			// Idle bus with a quiet target
			redirect.valid  = 1'b0;
			redirect.target = '0;
		end
	end

	// ========================================
	// Checks
	// ========================================

	// Each branch class raises at most one source across three separate units
	// Two at once means the decoder and a peer disagree
	a_one_request: assert property (@(posedge clk)
		$onehot0(req_vec))
		else $error("more than one redirect request valid");

endmodule

// File: hw/branch_decode_top.sv
// Branch decode and redirect top level
module branch_decode_top #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 instr_valid,
	input  brdec_pkg::micro_op_t instr,
	input  brdec_pkg::addr_t     pc,
	input  brdec_pkg::addr_t     eret_pc,
	output brdec_pkg::redirect_t redirect,
	output brdec_pkg::brclass_t  brclass_out,
	output logic                 class_valid
);

	import brdec_pkg::*;

	// Class of the micro-op now in decode
	brclass_t  brclass;

	// One request per redirect source
	redirect_t tgt_req;
	redirect_t ras_req;
	redirect_t eret_req;

	// Winner of this cycle before the output register
	redirect_t granted;

	// Output register split into control and payload
	logic      redirect_valid_q;
	addr_t     redirect_target_q;

	// ========================================
	// Classification and redirect sources
	// ========================================

	decode_brclass i_decode_brclass (
		.instr   (instr),
		.brclass (brclass)
	);

	branch_target i_branch_target (
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.brclass     (brclass),
		.tgt_req     (tgt_req)
	);

	// Stack state moves on the same edge that registers the result
	return_stack #(
		.RAS_DEPTH (RAS_DEPTH)
	) i_return_stack (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.brclass     (brclass),
		.pc          (pc),
		.ras_req     (ras_req)
	);

	// The exception return address is held outside so it needs no unit
	always_comb
	begin
		eret_req.valid  = instr_valid && (brclass == BRC_ERET);
		eret_req.target = eret_pc;
	end

	redirect_arbiter i_redirect_arbiter (
		.clk      (clk),
		.eret_req (eret_req),
		.ras_req  (ras_req),
		.tgt_req  (tgt_req),
		.redirect (granted)
	);

	// ========================================
	// Output registers
	// ========================================

	// Results show up one cycle after the strobe and last one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			redirect_valid_q <= 1'b0;
			class_valid      <= 1'b0;
			brclass_out      <= BRC_NONE;
		end
		else
		begin
			redirect_valid_q <= granted.valid;
			class_valid      <= instr_valid;
			// Idle cycles report no class
			brclass_out      <= instr_valid ? brclass : BRC_NONE;
		end
	end

	// Target is only meaningful alongside the valid bit
	always_ff @(posedge clk)
	begin
		redirect_target_q <= granted.target;
	end

	always_comb
	begin
		redirect.valid  = redirect_valid_q;
		redirect.target = redirect_target_q;
	end

endmodule

// File: verif/clock_gen.sv
// Testbench clock and reset
module clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset drops on a falling edge so the next rising edge sees it settled
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: verif/branch_decode_tb.sv
// Branch decode testbench
module branch_decode_tb;

	import brdec_pkg::*;

	localparam int RAS_DEPTH  = 8;
	localparam int CLK_PERIOD = 100;
	// Slots per phase in the order classify, drain, predict, nested, overflow, eret and idle
	localparam int NUM_INSTR = 30 + (RAS_DEPTH + 1) + 24 + 14 + (2 * RAS_DEPTH + 5) + 12 + 6;
	localparam int WATCHDOG_TIME = (NUM_INSTR + 50) * CLK_PERIOD;

	// BCC opcodes sit at indices 4 to 11
	localparam opcode_t ALL_OPS [14] = '{OP_NOP, OP_ADD, OP_JSR, OP_JSRN,
		OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64, OP_BCCU8, OP_BCCU16, OP_BCCU32, OP_BCCU64,
		OP_RTD, OP_BRK};

	logic      clk;
	logic      reset;
	logic      instr_valid;
	micro_op_t instr;
	addr_t     pc;
	addr_t     eret_pc;
	redirect_t redirect;
	brclass_t  brclass_out;
	logic      class_valid;

	// Expected result of the micro-op being driven now
	brclass_t  next_class;
	logic      next_cv;
	logic      next_rv;
	addr_t     next_tgt;
	string     next_name;

	// Expected result now on the DUT outputs
	brclass_t  exp_class;
	logic      exp_cv;
	logic      exp_rv;
	addr_t     exp_tgt;
	string     exp_name;

	// Newest return address at the back
	addr_t       ras_model [$];
	addr_t       cur_pc;
	logic [15:0] lfsr;
	string       test_name;
	logic        started = 1'b0;
	int          issued;
	int          mismatches;
	int          failures;

	clock_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (10)
	) i_clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	branch_decode_top #(
		.RAS_DEPTH (RAS_DEPTH)
	) i_branch_decode_top (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.eret_pc     (eret_pc),
		.redirect    (redirect),
		.brclass_out (brclass_out),
		.class_valid (class_valid)
	);

	// ========================================
	// Random source and reference model
	// ========================================

	// Taps 16, 14, 13 and 11 give a maximal length sequence
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic brclass_t expected_class(input opcode_t op, input logic md,
		input logic [7:0] func);
		case (op)
			OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64,
			OP_BCCU8, OP_BCCU16, OP_BCCU32, OP_BCCU64:
			begin
				if (md)
					return BRC_BCCR;
				return BRC_BCCD;
			end
			OP_JSR:  return BRC_JSR;
			OP_JSRN: return BRC_JSRN;
			OP_RTD:  return BRC_RTD;
			OP_BRK:
			begin
				if (func == 8'd1)
					return BRC_ERET;
				return BRC_NONE;
			end
			default: return BRC_NONE;
		endcase
	endfunction

	// Full stack loses its oldest entry
	task automatic push_model(input addr_t ret);
		ras_model.push_back(ret);
		if (ras_model.size() > RAS_DEPTH)
			ras_model.delete(0);
	endtask

	task automatic send_op(input opcode_t op, input logic md, input logic [7:0] func,
		input logic [15:0] disp);
		brclass_t    cls;
		addr_t       disp_ext;
		logic [31:0] rnd;
		@(negedge clk);
		take_bits(32, rnd);
		cls          = expected_class(op, md, func);
		disp_ext     = {{16{disp[15]}}, disp};
		eret_pc      = rnd;
		instr_valid  = 1'b1;
		instr.md      = md;
		instr.func    = func;
		instr.disp_lo = disp;
		instr.opcode  = op;
		pc           = cur_pc;
		next_class   = cls;
		next_cv      = 1'b1;
		next_rv      = 1'b0;
		next_tgt     = '0;
		next_name    = test_name;
		case (cls)
			// Only backward displacement branches are predicted taken
			BRC_BCCD:
			begin
				if (disp[15])
				begin
					next_rv  = 1'b1;
					next_tgt = cur_pc + disp_ext;
				end
			end
			BRC_JSR:
			begin
				next_rv  = 1'b1;
				next_tgt = cur_pc + disp_ext;
				push_model(cur_pc + 32'd4);
			end
			BRC_JSRN: push_model(cur_pc + 32'd4);
			BRC_RTD:
			begin
				if (ras_model.size() > 0)
				begin
					next_rv  = 1'b1;
					next_tgt = ras_model.pop_back();
				end
			end
			BRC_ERET:
			begin
				next_rv  = 1'b1;
				next_tgt = eret_pc;
			end
			default: ;
		endcase
		cur_pc = cur_pc + 32'd4;
		issued++;
	endtask

	// Junk on the instruction bus must be ignored while the strobe is low
	task automatic idle_cycle();
		logic [31:0] rnd;
		@(negedge clk);
		take_bits(32, rnd);
		instr_valid = 1'b0;
		instr       = micro_op_t'(rnd);
		next_class  = BRC_NONE;
		next_cv     = 1'b0;
		next_rv     = 1'b0;
		next_tgt    = '0;
		next_name   = test_name;
	endtask

	// The DUT registers on this edge, so the expectation moves along with it
	always @(posedge clk)
	begin
		started   <= 1'b1;
		exp_class <= next_class;
		exp_cv    <= next_cv;
		exp_rv    <= next_rv;
		exp_tgt   <= next_tgt;
		exp_name  <= next_name;
	end

	// ========================================
	// Checks on the falling edge
	// ========================================

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		mismatches++;
		$display("Mismatch %s %s expected %0h actual %0h", exp_name, what, expected, actual);
	endtask

	a_class_valid: assert property (@(negedge clk) disable iff (reset || !started)
		class_valid == exp_cv)
		else report_mismatch("class_valid", 32'(exp_cv), 32'(class_valid));

	a_brclass: assert property (@(negedge clk) disable iff (reset || !started)
		brclass_out == exp_class)
		else report_mismatch("brclass_out", 32'(exp_class), 32'(brclass_out));

	a_redirect_valid: assert property (@(negedge clk) disable iff (reset || !started)
		redirect.valid == exp_rv)
		else report_mismatch("redirect.valid", 32'(exp_rv), 32'(redirect.valid));

	a_redirect_target: assert property (@(negedge clk) disable iff (reset || !started)
		exp_rv |-> redirect.target == exp_tgt)
		else report_mismatch("redirect.target", exp_tgt, redirect.target);

	a_reset_idle: assert property (@(negedge clk)
		(started && reset) |-> (!class_valid && !redirect.valid && brclass_out == BRC_NONE))
		else
		begin
			failures++;
			$display("Outputs were not idle while reset was held");
		end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired before the stimulus finished");
		$display("Done: errors found");
		$finish;
	end

	// ========================================
	// Stimulus
	// ========================================

	initial
	begin
		logic [31:0] rnd;
		logic [31:0] fnc;
		logic        md_bit;
		opcode_t     op;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		eret_pc     = '0;
		next_class  = BRC_NONE;
		next_cv     = 1'b0;
		next_rv     = 1'b0;
		next_tgt    = '0;
		next_name   = "reset";
		test_name   = "reset";
		lfsr        = 16'd42671;
		cur_pc      = 32'h0000_1000;
		issued      = 0;
		mismatches  = 0;
		failures    = 0;
		@(negedge reset);

		// Every opcode in both modes, BRK with the exception return code and without
		test_name = "classify";
		for (int i = 0; i < 14; i++)
		begin
			for (int m = 0; m < 2; m++)
			begin
				md_bit = (m == 1);
				take_bits(16, rnd);
				take_bits(8, fnc);
				if (ALL_OPS[i] == OP_BRK)
					fnc = md_bit ? {24'd0, fnc[7:2], 2'b10} : 32'd1;
				send_op(ALL_OPS[i], md_bit, fnc[7:0], rnd[15:0]);
			end
		end
		send_op(OP_BRK, 1'b0, 8'h5a, 16'h0000);
		send_op(OP_BRK, 1'b1, 8'h01, 16'h0000);

		// Empty the stack so the last return finds nothing
		test_name = "drain";
		for (int i = 0; i < RAS_DEPTH + 1; i++)
			send_op(OP_RTD, 1'b0, 8'h00, 16'h0000);

		test_name = "predict";
		for (int i = 0; i < 24; i++)
		begin
			take_bits(3, rnd);
			op = ALL_OPS[4 + int'(rnd[2:0])];
			take_bits(1, fnc);
			take_bits(16, rnd);
			send_op(op, fnc[0], 8'h00, rnd[15:0]);
		end

		// Returns pair with the calls in reverse order
		test_name = "nested";
		for (int r = 0; r < 2; r++)
		begin
			take_bits(16, rnd);
			send_op(OP_JSR, 1'b0, 8'h00, rnd[15:0]);
			send_op(OP_JSRN, 1'b1, 8'h00, 16'h0000);
			take_bits(16, rnd);
			send_op(OP_JSR, 1'b0, 8'h00, rnd[15:0]);
			for (int k = 0; k < 3; k++)
				send_op(OP_RTD, 1'b0, 8'h00, 16'h0000);
			idle_cycle();
		end

		// Overflow keeps only the newest entries
		test_name = "overflow";
		for (int i = 0; i < RAS_DEPTH + 3; i++)
		begin
			take_bits(16, rnd);
			send_op((i % 2 == 0) ? OP_JSR : OP_JSRN, 1'b0, 8'h00, rnd[15:0]);
		end
		for (int i = 0; i < RAS_DEPTH + 2; i++)
			send_op(OP_RTD, 1'b0, 8'h00, 16'h0000);

		test_name = "eret";
		for (int i = 0; i < 6; i++)
		begin
			send_op(OP_BRK, 1'b0, 8'h01, 16'h0000);
			idle_cycle();
		end

		test_name = "idle";
		repeat (6) idle_cycle();
		// The last cycle's result is registered on the first edge and checked before the second
		repeat (2) @(posedge clk);

		$display("Instructions %0d, mismatches %0d, other failures %0d",
			issued, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: sources.f
hw/brdec_pkg.sv
hw/decode_brclass.sv
hw/branch_target.sv
hw/return_stack.sv
hw/redirect_arbiter.sv
hw/branch_decode_top.sv
verif/clock_gen.sv
verif/branch_decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the branch decode simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module branch_decode_tb \
	-f sources.f \
	--Mdir obj_dir -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
